// ==== Makefile ====
SIM     := obj_dir/Vicache_tb
SOURCES := $(filter-out +%,$(shell cat vlog.f))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) vlog.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f vlog.f --top-module icache_tb -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	  echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== hdl/icache_arrays.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_arrays #(
  parameter int  NUM_LINES  = 16,
  parameter int  LINE_WORDS = 4,
  localparam int IDX_W      = $clog2(NUM_LINES),
  localparam int OFF_W      = $clog2(LINE_WORDS),
  localparam int TAG_W      = icache_pkg::tag_width(NUM_LINES, LINE_WORDS)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        arr_rd_en,
  input  logic [icache_pkg::XLEN-1:0] cache_rd_addr,
  input  logic                        arr_wr_en,
  input  logic [IDX_W-1:0]            arr_wr_index,
  input  logic [OFF_W-1:0]            arr_wr_offset,
  input  logic [icache_pkg::XLEN-1:0] arr_wr_data,
  input  logic                        tag_wr_en,
  input  logic [TAG_W-1:0]            arr_wr_tag,
  output logic                        rd_tag_match,
  output logic [icache_pkg::XLEN-1:0] rd_word
);

  localparam int WORD_LSB = icache_pkg::WORD_LSB;
  localparam int IDX_LSB  = icache_pkg::index_lsb(LINE_WORDS);
  localparam int TAG_LSB  = icache_pkg::tag_lsb(NUM_LINES, LINE_WORDS);

  logic [TAG_W-1:0]            tag_mem [NUM_LINES];
  logic [icache_pkg::XLEN-1:0] data_mem [NUM_LINES*LINE_WORDS];
  logic [NUM_LINES-1:0]        line_valid;

  logic [IDX_W-1:0] rd_index;
  logic [OFF_W-1:0] rd_offset;
  logic [TAG_W-1:0] rd_tag;

  // Address fields of the lookup
  assign rd_index  = cache_rd_addr[TAG_LSB-1:IDX_LSB];
  assign rd_offset = cache_rd_addr[IDX_LSB-1:WORD_LSB];
  assign rd_tag    = cache_rd_addr[icache_pkg::XLEN-1:TAG_LSB];

  // Cache starts empty
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_valid <= '0;
    end else if (tag_wr_en) begin
      line_valid[arr_wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr_en) begin
      tag_mem[arr_wr_index] <= arr_wr_tag;
    end
  end

  // Data words stored line by line
  always_ff @(posedge clk) begin
    if (arr_wr_en) begin
      data_mem[{arr_wr_index, arr_wr_offset}] <= arr_wr_data;
    end
  end

  // Synchronous read, compare result registered with the word
  always_ff @(posedge clk) begin
    if (arr_rd_en) begin
      rd_word      <= data_mem[{rd_index, rd_offset}];
      rd_tag_match <= line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int  NUM_LINES  = 16,
  parameter int  LINE_WORDS = 4,
  localparam int IDX_W      = $clog2(NUM_LINES),
  localparam int OFF_W      = $clog2(LINE_WORDS),
  localparam int TAG_W      = icache_pkg::tag_width(NUM_LINES, LINE_WORDS)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cache_rd_valid,
  input  logic [icache_pkg::XLEN-1:0] cache_rd_addr,
  output logic                        cache_rd_ready,
  output logic [icache_pkg::XLEN-1:0] cache_rd_data,
  output logic                        cache_rd_data_valid,
  output logic                        cache_rd_hit,
  input  logic                        rd_tag_match,
  input  logic [icache_pkg::XLEN-1:0] rd_word,
  output logic                        arr_rd_en,
  output logic                        arr_wr_en,
  output logic [IDX_W-1:0]            arr_wr_index,
  output logic [OFF_W-1:0]            arr_wr_offset,
  output logic [icache_pkg::XLEN-1:0] arr_wr_data,
  output logic                        tag_wr_en,
  output logic [TAG_W-1:0]            arr_wr_tag,
  output logic                        cnt_clear,
  output logic                        ar_step,
  output logic                        r_step,
  input  logic [OFF_W-1:0]            ar_offset,
  input  logic [OFF_W-1:0]            r_offset,
  input  logic                        ar_last,
  input  logic                        r_last,
  output logic                        m_arvalid,
  output logic [icache_pkg::XLEN-1:0] m_araddr,
  input  logic                        m_arready,
  input  logic                        m_rvalid,
  input  logic [icache_pkg::XLEN-1:0] m_rdata,
  output logic                        m_rready
);

  localparam int WORD_LSB = icache_pkg::WORD_LSB;
  localparam int IDX_LSB  = icache_pkg::index_lsb(LINE_WORDS);
  localparam int TAG_LSB  = icache_pkg::tag_lsb(NUM_LINES, LINE_WORDS);

  icache_pkg::ctrl_state_t state;
  icache_pkg::ctrl_state_t state_next;

  logic [icache_pkg::XLEN-1:0] req_addr;
  logic                        rd_fire;
  logic                        lookup_pending;
  logic                        resp_pending;
  logic                        ar_all_sent;
  logic                        miss;

  // Requests are taken only while idle in lookup
  assign cache_rd_ready = (state == icache_pkg::CTRL_LOOKUP);
  assign rd_fire        = cache_rd_valid && cache_rd_ready;

  // Tag result arrives one cycle after the accepted request
  assign cache_rd_hit        = lookup_pending && rd_tag_match;
  assign miss                = lookup_pending && !rd_tag_match;
  assign cache_rd_data_valid = cache_rd_hit || resp_pending;
  assign cache_rd_data       = rd_word;

  // Array read on a new request, and again once the line is in
  assign arr_rd_en = rd_fire || (state == icache_pkg::CTRL_RESPOND);

  // Refill addresses walk up from the line base
  assign m_arvalid = (state == icache_pkg::CTRL_REFILL_AR);
  assign m_araddr  = {req_addr[icache_pkg::XLEN-1:IDX_LSB], ar_offset, {WORD_LSB{1'b0}}};
  assign m_rready  = (state == icache_pkg::CTRL_REFILL_R);

  assign ar_step   = m_arvalid && m_arready;
  assign r_step    = m_rready && m_rvalid;
  assign cnt_clear = miss;

  // Each R beat lands in the line of the missed address
  assign arr_wr_en     = r_step;
  assign arr_wr_index  = req_addr[TAG_LSB-1:IDX_LSB];
  assign arr_wr_offset = r_offset;
  assign arr_wr_data   = m_rdata;
  // Line becomes valid together with its last word
  assign tag_wr_en     = r_step && r_last;
  assign arr_wr_tag    = req_addr[icache_pkg::XLEN-1:TAG_LSB];

  always_comb begin
    state_next = state;
    unique case (state)
      icache_pkg::CTRL_LOOKUP: begin
        if (miss) begin
          state_next = icache_pkg::CTRL_REFILL_AR;
        end
      end
      icache_pkg::CTRL_REFILL_AR: begin
        if (ar_step) begin
          state_next = icache_pkg::CTRL_REFILL_R;
        end
      end
      icache_pkg::CTRL_REFILL_R: begin
        if (r_step) begin
          if (r_last) begin
            state_next = icache_pkg::CTRL_RESPOND;
          end else if (!ar_all_sent) begin
            state_next = icache_pkg::CTRL_REFILL_AR;
          end
        end
      end
      icache_pkg::CTRL_RESPOND: state_next = icache_pkg::CTRL_LOOKUP;
      default:                  state_next = icache_pkg::CTRL_LOOKUP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= icache_pkg::CTRL_LOOKUP;
      lookup_pending <= 1'b0;
      resp_pending   <= 1'b0;
      ar_all_sent    <= 1'b0;
    end else begin
      state          <= state_next;
      lookup_pending <= rd_fire;
      // Miss data goes out the cycle after the re-read
      resp_pending   <= (state == icache_pkg::CTRL_RESPOND);
      if (cnt_clear) begin
        ar_all_sent <= 1'b0;
      end else if (ar_step && ar_last) begin
        ar_all_sent <= 1'b1;
      end
    end
  end

  // Address of the request being looked up or refilled
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      req_addr <= cache_rd_addr;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // Instruction and address width
  localparam int XLEN = 32;

  // Bytes per instruction word, and the address bits below the word
  localparam int WORD_BYTES = 4;
  localparam int WORD_LSB   = $clog2(WORD_BYTES);

  // Cache controller states
  typedef enum {
    CTRL_LOOKUP,
    CTRL_REFILL_AR,
    CTRL_REFILL_R,
    CTRL_RESPOND
  } ctrl_state_t;

  // CPU bridge states
  typedef enum {
    BRIDGE_IDLE,
    BRIDGE_WAIT
  } bridge_state_t;

  // Lowest address bit of the line index
  function automatic int index_lsb(input int line_words);
    return WORD_LSB + $clog2(line_words);
  endfunction

  // Lowest address bit of the tag
  function automatic int tag_lsb(input int num_lines, input int line_words);
    return index_lsb(line_words) + $clog2(num_lines);
  endfunction

  // Tag width for a given geometry
  function automatic int tag_width(input int num_lines, input int line_words);
    return XLEN - tag_lsb(num_lines, line_words);
  endfunction

endpackage

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int NUM_LINES  = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        imem_ren,
  input  logic [icache_pkg::XLEN-1:0] imem_raddr,
  output logic [icache_pkg::XLEN-1:0] imem_rdata,
  output logic                        imem_stall,
  output logic                        m_arvalid,
  output logic [icache_pkg::XLEN-1:0] m_araddr,
  input  logic                        m_arready,
  input  logic                        m_rvalid,
  input  logic [icache_pkg::XLEN-1:0] m_rdata,
  output logic                        m_rready
);

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int TAG_W = icache_pkg::tag_width(NUM_LINES, LINE_WORDS);

  // Bridge to controller
  logic                        cache_rd_valid;
  logic [icache_pkg::XLEN-1:0] cache_rd_addr;
  logic                        cache_rd_ready;
  logic [icache_pkg::XLEN-1:0] cache_rd_data;
  logic                        cache_rd_data_valid;
  logic                        cache_rd_hit;

  // Controller to arrays
  logic                        rd_tag_match;
  logic [icache_pkg::XLEN-1:0] rd_word;
  logic                        arr_rd_en;
  logic                        arr_wr_en;
  logic [IDX_W-1:0]            arr_wr_index;
  logic [OFF_W-1:0]            arr_wr_offset;
  logic [icache_pkg::XLEN-1:0] arr_wr_data;
  logic                        tag_wr_en;
  logic [TAG_W-1:0]            arr_wr_tag;

  // Controller to refill counter
  logic                        cnt_clear;
  logic                        ar_step;
  logic                        r_step;
  logic [OFF_W-1:0]            ar_offset;
  logic [OFF_W-1:0]            r_offset;
  logic                        ar_last;
  logic                        r_last;

  imem_cache_bridge u_bridge (
    .clk                 (clk),
    .rst_n               (rst_n),
    .imem_ren            (imem_ren),
    .imem_raddr          (imem_raddr),
    .imem_rdata          (imem_rdata),
    .imem_stall          (imem_stall),
    .cache_rd_valid      (cache_rd_valid),
    .cache_rd_addr       (cache_rd_addr),
    .cache_rd_ready      (cache_rd_ready),
    .cache_rd_data       (cache_rd_data),
    .cache_rd_data_valid (cache_rd_data_valid),
    .cache_rd_hit        (cache_rd_hit)
  );

  icache_ctrl #(
    .NUM_LINES  (NUM_LINES),
    .LINE_WORDS (LINE_WORDS)
  ) u_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cache_rd_valid      (cache_rd_valid),
    .cache_rd_addr       (cache_rd_addr),
    .cache_rd_ready      (cache_rd_ready),
    .cache_rd_data       (cache_rd_data),
    .cache_rd_data_valid (cache_rd_data_valid),
    .cache_rd_hit        (cache_rd_hit),
    .rd_tag_match        (rd_tag_match),
    .rd_word             (rd_word),
    .arr_rd_en           (arr_rd_en),
    .arr_wr_en           (arr_wr_en),
    .arr_wr_index        (arr_wr_index),
    .arr_wr_offset       (arr_wr_offset),
    .arr_wr_data         (arr_wr_data),
    .tag_wr_en           (tag_wr_en),
    .arr_wr_tag          (arr_wr_tag),
    .cnt_clear           (cnt_clear),
    .ar_step             (ar_step),
    .r_step              (r_step),
    .ar_offset           (ar_offset),
    .r_offset            (r_offset),
    .ar_last             (ar_last),
    .r_last              (r_last),
    .m_arvalid           (m_arvalid),
    .m_araddr            (m_araddr),
    .m_arready           (m_arready),
    .m_rvalid            (m_rvalid),
    .m_rdata             (m_rdata),
    .m_rready            (m_rready)
  );

  refill_counter #(
    .LINE_WORDS (LINE_WORDS)
  ) u_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .cnt_clear (cnt_clear),
    .ar_step   (ar_step),
    .r_step    (r_step),
    .ar_offset (ar_offset),
    .r_offset  (r_offset),
    .ar_last   (ar_last),
    .r_last    (r_last)
  );

  // Array read address comes straight from the bridge
  icache_arrays #(
    .NUM_LINES  (NUM_LINES),
    .LINE_WORDS (LINE_WORDS)
  ) u_arrays (
    .clk           (clk),
    .rst_n         (rst_n),
    .arr_rd_en     (arr_rd_en),
    .cache_rd_addr (cache_rd_addr),
    .arr_wr_en     (arr_wr_en),
    .arr_wr_index  (arr_wr_index),
    .arr_wr_offset (arr_wr_offset),
    .arr_wr_data   (arr_wr_data),
    .tag_wr_en     (tag_wr_en),
    .arr_wr_tag    (arr_wr_tag),
    .rd_tag_match  (rd_tag_match),
    .rd_word       (rd_word)
  );

endmodule

`default_nettype wire

// ==== hdl/imem_cache_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_cache_bridge (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        imem_ren,
  input  logic [icache_pkg::XLEN-1:0] imem_raddr,
  output logic [icache_pkg::XLEN-1:0] imem_rdata,
  output logic                        imem_stall,
  output logic                        cache_rd_valid,
  output logic [icache_pkg::XLEN-1:0] cache_rd_addr,
  input  logic                        cache_rd_ready,
  input  logic [icache_pkg::XLEN-1:0] cache_rd_data,
  input  logic                        cache_rd_data_valid,
  input  logic                        cache_rd_hit
);

  // Reset value of the fetched word is a NOP (addi x0, x0, 0)
  localparam logic [icache_pkg::XLEN-1:0] NOP = 32'h0000_0013;

  icache_pkg::bridge_state_t state;
  icache_pkg::bridge_state_t state_next;

  logic                        rd_start;
  logic                        rd_fire;
  logic                        rd_fire_q;
  logic                        miss_detected;
  logic                        miss_inflight;
  logic                        miss_return_hold;
  logic [icache_pkg::XLEN-1:0] addr_hold;
  logic [icache_pkg::XLEN-1:0] rdata_hold;
  logic                        rdata_hold_valid;

  // A request accepted last cycle without a hit is a miss
  assign miss_detected = rd_fire_q && !cache_rd_hit && !miss_inflight;

  // New fetches only start when no miss is being serviced
  assign rd_start = (state == icache_pkg::BRIDGE_IDLE) && imem_ren &&
                    !miss_inflight && !miss_return_hold && !miss_detected;

  assign cache_rd_valid = rd_start || (state == icache_pkg::BRIDGE_WAIT);
  assign rd_fire        = cache_rd_valid && cache_rd_ready;

  assign imem_stall = (state == icache_pkg::BRIDGE_WAIT) || miss_inflight ||
                      miss_return_hold || miss_detected;

  // Held address while waiting on ready or while the refill is running,
  // so the array re-read after refill sees the original fetch address.
  // Both selects are registered, keeping the hit path out of the array address
  assign cache_rd_addr = ((state == icache_pkg::BRIDGE_WAIT) || miss_inflight) ?
                         addr_hold : imem_raddr;

  always_comb begin
    state_next = state;
    unique case (state)
      icache_pkg::BRIDGE_IDLE: begin
        // Cache busy, keep the request up
        if (rd_start && !cache_rd_ready) begin
          state_next = icache_pkg::BRIDGE_WAIT;
        end
      end
      icache_pkg::BRIDGE_WAIT: begin
        if (cache_rd_ready) begin
          state_next = icache_pkg::BRIDGE_IDLE;
        end
      end
      default: state_next = icache_pkg::BRIDGE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= icache_pkg::BRIDGE_IDLE;
      rd_fire_q        <= 1'b0;
      miss_inflight    <= 1'b0;
      miss_return_hold <= 1'b0;
      rdata_hold_valid <= 1'b0;
    end else begin
      state     <= state_next;
      rd_fire_q <= rd_fire;
      // Return hold lasts exactly one cycle
      miss_return_hold <= 1'b0;
      if (cache_rd_data_valid) begin
        rdata_hold_valid <= 1'b1;
        // Miss response ends the in-flight phase, one more stall cycle follows
        if (miss_inflight) begin
          miss_inflight    <= 1'b0;
          miss_return_hold <= 1'b1;
        end
      end else if (miss_detected) begin
        miss_inflight <= 1'b1;
      end
    end
  end

  // Fetch address kept for back-pressure and refill
  always_ff @(posedge clk) begin
    if (rd_start) begin
      addr_hold <= imem_raddr;
    end
  end

  // Last word returned by the cache
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_hold <= NOP;
    end else if (cache_rd_data_valid) begin
      rdata_hold <= cache_rd_data;
    end
  end

  // Live cache data wins over the held word
  always_comb begin
    if (cache_rd_data_valid) begin
      imem_rdata = cache_rd_data;
    end else if (imem_stall || rdata_hold_valid) begin
      imem_rdata = rdata_hold;
    end else begin
      imem_rdata = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/refill_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_counter #(
  parameter int  LINE_WORDS = 4,
  localparam int OFF_W      = $clog2(LINE_WORDS)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cnt_clear,
  input  logic             ar_step,
  input  logic             r_step,
  output logic [OFF_W-1:0] ar_offset,
  output logic [OFF_W-1:0] r_offset,
  output logic             ar_last,
  output logic             r_last
);

  localparam logic [OFF_W-1:0] LAST_OFFSET = OFF_W'(LINE_WORDS - 1);

  // Issued addresses and received beats count separately
  always_ff @(posedge clk) begin
    if (!rst_n || cnt_clear) begin
      ar_offset <= '0;
      r_offset  <= '0;
    end else begin
      // Power-of-two line size, so the counters wrap on their own
      if (ar_step) begin
        ar_offset <= ar_offset + 1'b1;
      end
      if (r_step) begin
        r_offset <= r_offset + 1'b1;
      end
    end
  end

  assign ar_last = (ar_offset == LAST_OFFSET);
  assign r_last  = (r_offset == LAST_OFFSET);

endmodule

`default_nettype wire

// ==== tb/icache_stim.txt ====
// Columns: fetch address, expected hit (1) or miss (0), expected instruction
// 16 lines of 4 words, index is address bits 7:4
00000100 0 A4C30100
00000104 1 A4C70104
00000108 1 A4CB0108
0000010C 1 A4CF010C
00000100 1 A4C30100
00000210 0 A7D30210
0000021C 1 A7DF021C
00000108 1 A4CB0108
// Same index as 0x100, other tag
00001104 0 B4C71104
00001100 1 B4C31100
00000100 0 A4C30100
00001108 0 B4CB1108
// Last index
000003F4 0 A63703F4
000003F0 1 A63303F0
000003FC 1 A63F03FC
00000214 1 A7D70214
0000ABC8 0 0E0BABC8
0000ABCC 1 0E0FABCC
0001ABC0 0 0E03ABC0
0000ABC8 0 0E0BABC8
0001ABC4 0 0E07ABC4
00000F00 0 AAC30F00
00000F0C 1 AACF0F0C
000003F8 1 A63B03F8
0000021C 1 A7DF021C
00000104 0 A4C70104
// High address bits only differ in the tag
80000030 0 A5F30030
00000034 0 A5F70034
80000038 0 A5FB0038

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int NUM_LINES   = 16;
  localparam int LINE_WORDS  = 4;
  localparam int MAX_FETCHES = 64;
  localparam int LINE_BYTES  = LINE_WORDS * icache_pkg::WORD_BYTES;
  localparam logic [31:0] LINE_MASK = 32'(LINE_BYTES - 1);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        imem_stall;
  logic        m_arvalid;
  logic [31:0] m_araddr;
  logic        m_arready = 1'b0;
  logic        m_rvalid = 1'b0;
  logic [31:0] m_rdata = '0;
  logic        m_rready;

  // Raw file words, three per fetch
  logic [31:0] stim_raw [3*MAX_FETCHES];
  logic [31:0] fetch_addr [MAX_FETCHES];
  logic        exp_hit [MAX_FETCHES];
  logic [31:0] exp_data [MAX_FETCHES];
  int          num_fetches = 0;
  logic        stim_loaded = 1'b0;

  int error_count = 0;
  int check_count = 0;

  // Memory model state
  integer      seed = 32'h5101_2c9c;
  int          ar_wait = 0;
  int          r_wait = 0;
  logic        r_pending = 1'b0;
  logic [31:0] r_addr = '0;
  // Address of the fetch in progress, and its AR handshakes so far
  logic [31:0] cur_addr = '0;
  int          ar_count = 0;

  // 40 ns clock
  always #20 clk = ~clk;

  icache_top #(
    .NUM_LINES  (NUM_LINES),
    .LINE_WORDS (LINE_WORDS)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .imem_stall (imem_stall),
    .m_arvalid  (m_arvalid),
    .m_araddr   (m_araddr),
    .m_arready  (m_arready),
    .m_rvalid   (m_rvalid),
    .m_rdata    (m_rdata),
    .m_rready   (m_rready)
  );

  // Backing memory content, low half is the address, high half scrambled
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[15:0] ^ 16'hA5C3, addr[15:0]};
  endfunction

  // Handshake delay of 0 to 3 cycles
  function automatic int pick_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  // AXI4-Lite read slave, decides each cycle at the falling edge
  always @(negedge clk) begin
    logic [31:0] want_addr;
    if (!rst_n) begin
      m_arready = 1'b0;
      m_rvalid  = 1'b0;
      r_pending = 1'b0;
      ar_wait   = pick_delay();
    end else begin
      // R first, so no beat goes out in the cycle of its own address
      m_rvalid = 1'b0;
      if (r_pending) begin
        if (r_wait == 0) begin
          m_rvalid = 1'b1;
          m_rdata  = mem_word(r_addr);
          // Beat taken at the coming rising edge
          if (m_rready) begin
            r_pending = 1'b0;
          end
        end else begin
          r_wait = r_wait - 1;
        end
      end
      m_arready = 1'b0;
      if (m_arvalid && !r_pending) begin
        if (ar_wait == 0) begin
          m_arready = 1'b1;
          // Refill walks up word by word from the line base
          want_addr = (cur_addr & ~LINE_MASK) + 32'(ar_count * icache_pkg::WORD_BYTES);
          check_count++;
          assert (m_araddr == want_addr) else begin
            $display("Error at %0d ns: AR address %h, expected %h",
                     $time, m_araddr, want_addr);
            error_count++;
          end
          ar_count++;
          r_addr    = m_araddr;
          r_pending = 1'b1;
          r_wait    = pick_delay();
          ar_wait   = pick_delay();
        end else begin
          ar_wait = ar_wait - 1;
        end
      end
    end
  end

  // Read the fetch table, a hit flag other than 0 or 1 ends it
  task automatic load_stimulus();
    for (int k = 0; k < 3*MAX_FETCHES; k++) begin
      stim_raw[k] = 32'hFFFF_FFFF;
    end
    $readmemh("tb/icache_stim.txt", stim_raw);
    while (num_fetches < MAX_FETCHES && stim_raw[3*num_fetches+1] <= 32'd1) begin
      fetch_addr[num_fetches] = stim_raw[3*num_fetches];
      exp_hit[num_fetches]    = stim_raw[3*num_fetches+1][0];
      exp_data[num_fetches]   = stim_raw[3*num_fetches+2];
      num_fetches++;
    end
    stim_loaded = 1'b1;
  endtask

  // One request pulse, then wait out the stall and check the result
  task automatic run_fetch(input int idx);
    int          errs_before;
    int          wait_cycles;
    int          want_ars;
    logic        stall_first;
    logic [31:0] got;
    string       kind;
    string       verdict;
    errs_before = error_count;
    cur_addr    = fetch_addr[idx];
    ar_count    = 0;
    imem_raddr  = fetch_addr[idx];
    imem_ren    = 1'b1;
    @(negedge clk);
    imem_ren    = 1'b0;
    // First cycle after the request tells hit from miss
    stall_first = imem_stall;
    wait_cycles = 0;
    while (imem_stall) begin
      @(negedge clk);
      wait_cycles++;
    end
    got = imem_rdata;
    if (exp_hit[idx]) begin
      want_ars = 0;
    end else begin
      want_ars = LINE_WORDS;
    end
    check_count += 3;
    assert (stall_first == !exp_hit[idx]) else begin
      $display("Error at %0d ns: fetch %0d stall after request %b, expected %b",
               $time, idx, stall_first, !exp_hit[idx]);
      error_count++;
    end
    assert (got == exp_data[idx]) else begin
      $display("Error at %0d ns: fetch %0d data %h, expected %h",
               $time, idx, got, exp_data[idx]);
      error_count++;
    end
    assert (ar_count == want_ars) else begin
      $display("Error at %0d ns: fetch %0d saw %0d AR handshakes, expected %0d",
               $time, idx, ar_count, want_ars);
      error_count++;
    end
    if (stall_first) begin
      kind = "miss";
    end else begin
      kind = "hit";
    end
    if (error_count == errs_before) begin
      verdict = "ok";
    end else begin
      verdict = "FAILED";
    end
    $display("Fetch %0d at %h: %s, %0d stall cycles, %s",
             idx, fetch_addr[idx], kind, wait_cycles, verdict);
  endtask

  initial begin
    rst_n      = 1'b0;
    imem_ren   = 1'b0;
    imem_raddr = '0;
    load_stimulus();
    if (num_fetches == 0) begin
      $display("The stimulus file holds no fetches");
      error_count++;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle outputs out of reset
    check_count++;
    assert (!imem_stall && !m_arvalid && !m_rready) else begin
      $display("Error at %0d ns: stall %b arvalid %b rready %b after reset",
               $time, imem_stall, m_arvalid, m_rready);
      error_count++;
    end
    // Back to back, next request goes out in the cycle the data is taken
    for (int i = 0; i < num_fetches; i++) begin
      run_fetch(i);
    end
    $display("%0d fetches, %0d checks, %0d errors", num_fetches, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized for a full refill on every fetch
  initial begin
    int limit;
    wait (stim_loaded);
    limit = num_fetches * (LINE_WORDS * 8 + 10) + 20;
    repeat (limit) @(posedge clk);
    $display("Simulation timed out after %0d clock cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/icache_pkg.sv
hdl/refill_counter.sv
hdl/icache_arrays.sv
hdl/icache_ctrl.sv
hdl/imem_cache_bridge.sv
hdl/icache_top.sv
tb/icache_tb.sv
